/* sources.f */
common/trace_pkg.sv
rtl/trace_shifter.sv
rtl/trace_sync.sv
rtl/sync_filter.sv
matcher/pattern_matcher.sv
matcher/match_counters.sv
rtl/fifo_writer.sv
rtl/fe_capture_trace.sv
verif/tb_clock.sv
verif/tb_fe_capture_trace.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_fe_capture_trace -f sources.f

out=$(./obj_dir/Vtb_fe_capture_trace)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
   exit 0
else
   exit 1
fi

/* verif/tb_fe_capture_trace.sv */
`default_nettype none

module tb_fe_capture_trace;
   import trace_pkg::*;

   localparam int RULES   = 8;
   localparam int TIMEOUT = 200;  // cycles allowed per wait loop

   logic                                fe_clk;
   logic                                reset;
   logic [7:0]                          trace_data;
   logic                                trace_clock_sel;
   trace_width_e                        trace_width;
   logic                                resync;
   logic                                capture_raw;
   logic                                record_syncs;
   logic                                capturing;
   logic [RULES-1:0][BUFFER_BITS-1:0]   patterns;
   logic [RULES-1:0][BUFFER_BITS-1:0]   masks;
   logic [RULES-1:0]                    pattern_enable;
   logic [RULES-1:0]                    pattern_trig_enable;
   logic                                soft_trig_enable;
   logic                                arm;
   logic                                no_arm;
   logic                                ext_trig;
   logic                                fifo_wr_req;
   fe_cmd_e                             fifo_command;
   logic [FULL_TIME_BITS-1:0]           fifo_time;
   logic                                trace_event;
   fe_cmd_e                             data_cmd;
   logic                                sync_locked;
   logic [BUFFER_BITS-1:0]              rev_buffer;
   logic [RULES-1:0][COUNT_BITS-1:0]    trace_counts;
   logic [BUFFER_BITS-1:0]              matched_data;
   logic [FIFO_WORD_BITS-1:0]           fifo_data;
   logic                                fifo_wr;
   logic                                trigger_match;

   // reference state, all updated at the rising edge
   logic [BUFFER_BITS-1:0]              buf_model;
   logic [BUFFER_BITS-1:0]              buf_prev;
   logic [RULES-1:0][COUNT_BITS-1:0]    cnt_model;
   logic [RULES-1:0]                    rule_model;  // last latched hit vector
   logic [FIFO_WORD_BITS-1:0]           word_exp_r;
   trace_width_e                        width_prev;
   logic                                raw_r;
   logic                                cap_r;
   logic                                ext_prev;
   logic                                wr_prev;
   logic                                event_r;
   logic                                sync_only;   // only sync frames in flight
   logic [7:0]                          pat_byte;
   int                                  sync_idx;
   int                                  seed_ret;
   int                                  assert_errors = 0;
   int                                  timeout_errors = 0;
   trace_width_e                        widths [3] = '{WIDTH_1, WIDTH_2, WIDTH_4};

   tb_clock #(.PERIOD(4)) u_clock (.clk(fe_clk));

   fe_capture_trace #(.MATCH_RULES(RULES)) DUT (.*);

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////
   // newest sample lands at the top, low nibble lanes below high nibble lanes
   function automatic logic [BUFFER_BITS-1:0] shift_in(logic [BUFFER_BITS-1:0] cur,
         logic [7:0] d, trace_width_e w, logic tclk);
      int                     lanes;
      int                     n;
      logic [BUFFER_BITS-1:0] nxt;
      case (w)
         WIDTH_2: lanes = 2;
         WIDTH_4: lanes = 4;
         default: lanes = 1;
      endcase
      n   = tclk ? 2 * lanes : lanes;  // trace clock takes both phases
      nxt = cur >> n;
      for (int i = 0; i < lanes; i++) begin
         nxt[BUFFER_BITS-n+i] = d[i];
         if (tclk)
            nxt[BUFFER_BITS-n+lanes+i] = d[4+i];
      end
      return nxt;
   endfunction

   function automatic logic [RULES-1:0] rule_hits(logic [BUFFER_BITS-1:0] b);
      logic [RULES-1:0] h;
      for (int i = 0; i < RULES; i++)
         h[i] = (((b ^ patterns[i]) & masks[i]) == '0) && pattern_enable[i] &&
                (cap_r || pattern_trig_enable[i]);
      return h;
   endfunction

   // cmd at bit 0, time from bit 2, data byte from bit 10
   function automatic logic [FIFO_WORD_BITS-1:0] fifo_word(fe_cmd_e cmd,
         logic [FULL_TIME_BITS-1:0] t, logic [RULES-1:0] rule, logic [BUFFER_BITS-1:0] b,
         logic tclk);
      logic [7:0]                stat;
      logic [FIFO_WORD_BITS-1:0] w;
      stat = tclk ? b[31:24] : b[43:36];
      case (cmd)
         CMD_DATA: w = {8'(rule), t[7:0], cmd};
         CMD_STAT: w = {stat, t[7:0], cmd};
         CMD_TIME: w = {t, cmd};
         default:  w = {16'd0, cmd};
      endcase
      return w;
   endfunction

   always @(posedge fe_clk) begin : models
      logic [RULES-1:0] hits;
      hits = rule_hits(rev_buffer);
      buf_prev   <= rev_buffer;
      width_prev <= trace_width;
      ext_prev   <= ext_trig;
      event_r    <= trace_event;
      if (reset) begin
         buf_model  <= '0;
         cnt_model  <= '0;
         rule_model <= '0;
         raw_r      <= 1'b0;
         cap_r      <= 1'b0;
         wr_prev    <= 1'b0;
      end else begin
         buf_model <= shift_in(buf_model, trace_data, trace_width, trace_clock_sel);
         raw_r     <= capture_raw;
         cap_r     <= capturing;
         wr_prev   <= fifo_wr_req;
         if (fifo_wr_req)
            word_exp_r <= fifo_word(fifo_command, fifo_time, rule_model, rev_buffer,
                                    trace_clock_sel);
         if (trace_event && !raw_r) begin  // data mode, some rule hit
            rule_model <= hits;
            for (int i = 0; i < RULES; i++)
               if (hits[i])
                  cnt_model[i] <= cnt_model[i] + 8'd1;
         end
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////
   a_shift: assert property (@(posedge fe_clk) disable iff (reset) rev_buffer == buf_model)
      else begin
         assert_errors++;
         $display("ERROR rev_buffer got %h expected %h", $sampled(rev_buffer),
                  $sampled(buf_model));
      end
   a_lock_rise: assert property (@(posedge fe_clk) disable iff (reset)
      (!sync_locked && !resync && trace_width == width_prev &&
       rev_buffer[63:48] == SYNC_HEAD && rev_buffer[7:0] == SYNC_TAIL) |=> sync_locked)
      else begin
         assert_errors++;
         $display("ERROR sync_locked got %h expected 1", $sampled(sync_locked));
      end
   a_lock_resync: assert property (@(posedge fe_clk) disable iff (reset)
      resync |=> !sync_locked)
      else begin
         assert_errors++;
         $display("ERROR sync_locked got %h expected 0 after resync", $sampled(sync_locked));
      end
   a_lock_width: assert property (@(posedge fe_clk) disable iff (reset)
      (trace_width != width_prev) |=> !sync_locked)
      else begin
         assert_errors++;
         $display("ERROR sync_locked got %h expected 0 after width change",
                  $sampled(sync_locked));
      end
   a_counts: assert property (@(posedge fe_clk) disable iff (reset) trace_counts == cnt_model)
      else begin
         assert_errors++;
         $display("ERROR trace_counts got %h expected %h", $sampled(trace_counts),
                  $sampled(cnt_model));
      end
   a_matched: assert property (@(posedge fe_clk) disable iff (reset)
      (trace_event && !raw_r) |=> matched_data == buf_prev)
      else begin
         assert_errors++;
         $display("ERROR matched_data got %h expected %h", $sampled(matched_data),
                  $sampled(buf_prev));
      end
   a_trig_ext: assert property (@(posedge fe_clk) disable iff (reset)
      (arm && soft_trig_enable && ext_trig && !ext_prev) |-> trigger_match)
      else begin
         assert_errors++;
         $display("ERROR trigger_match got %h expected 1", $sampled(trigger_match));
      end
   a_trig_unarmed: assert property (@(posedge fe_clk) disable iff (reset)
      (!arm && !no_arm) |-> !trigger_match)
      else begin
         assert_errors++;
         $display("ERROR trigger_match got %h expected 0", $sampled(trigger_match));
      end
   a_fifo_wr: assert property (@(posedge fe_clk) disable iff (reset) fifo_wr == wr_prev)
      else begin
         assert_errors++;
         $display("ERROR fifo_wr got %h expected %h", $sampled(fifo_wr), $sampled(wr_prev));
      end
   a_fifo_word: assert property (@(posedge fe_clk) disable iff (reset)
      fifo_wr |-> fifo_data == word_exp_r)
      else begin
         assert_errors++;
         $display("ERROR fifo_data got %h expected %h", $sampled(fifo_data),
                  $sampled(word_exp_r));
      end
   a_raw_quiet: assert property (@(posedge fe_clk) disable iff (reset)
      (raw_r && sync_only) |-> !trace_event)
      else begin
         assert_errors++;
         $display("ERROR trace_event got %h expected 0 on sync frames", $sampled(trace_event));
      end
   a_data_cmd: assert property (@(posedge fe_clk) disable iff (reset)
      data_cmd == (raw_r ? CMD_STAT : CMD_DATA))
      else begin
         assert_errors++;
         $display("ERROR data_cmd got %h expected %h", $sampled(data_cmd),
                  $sampled(raw_r) ? CMD_STAT : CMD_DATA);
      end

   //////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////
   task automatic next_cycle();
      @(posedge fe_clk);
      #1;  // inputs move just after the edge
   endtask

   task automatic send_sync_bytes(input int n);
      repeat (n) begin
         next_cycle();
         trace_data = SYNC_ALL_WORDS[0][8*sync_idx +: 8];  // bottom byte goes first
         sync_idx   = (sync_idx + 1) % 8;
      end
   endtask

   task automatic send_random(input int n);
      repeat (n) begin
         next_cycle();
         trace_data = 8'($urandom);
      end
   endtask

   task automatic wait_lock();
      int n;
      n = 0;
      while (!sync_locked && n < TIMEOUT) begin
         send_sync_bytes(1);
         n++;
      end
      if (!sync_locked) begin
         timeout_errors++;
         $display("timeout: sync_locked never rose on a stream of sync frames");
      end
   endtask

   task automatic wait_counts(input logic [COUNT_BITS-1:0] target);
      int n;
      n = 0;
      while (trace_counts[0] < target && n < TIMEOUT) begin
         next_cycle();
         trace_data = n[0] ? pat_byte : 8'($urandom);  // hit on every other byte
         n++;
      end
      if (trace_counts[0] < target) begin
         timeout_errors++;
         $display("timeout: hit counter of rule 0 stopped short of its target");
      end
   endtask

   task automatic wait_raw_event();
      int n;
      n = 0;
      while (!event_r && n < TIMEOUT) begin
         next_cycle();
         trace_data = 8'h3c;  // not part of any sync frame
         n++;
      end
      if (!event_r) begin
         timeout_errors++;
         $display("timeout: no raw event after non-sync data");
      end
   endtask

   task automatic pulse_ext(input int n);
      repeat (n) begin
         next_cycle();
         ext_trig = 1'b1;
         next_cycle();
         ext_trig = 1'b0;
         next_cycle();
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      seed_ret            = $urandom(56);
      trace_data          = '0;
      trace_clock_sel     = 1'b1;
      trace_width         = WIDTH_4;
      resync              = 1'b0;
      capture_raw         = 1'b0;
      record_syncs        = 1'b0;
      capturing           = 1'b0;
      patterns            = '0;
      masks               = '0;
      pattern_enable      = '0;
      pattern_trig_enable = '0;
      soft_trig_enable    = 1'b0;
      arm                 = 1'b0;
      no_arm              = 1'b0;
      ext_trig            = 1'b0;
      fifo_wr_req         = 1'b0;
      fifo_command        = CMD_DATA;
      fifo_time           = '0;
      sync_idx            = 0;
      sync_only           = 1'b0;
      pat_byte            = '0;
      reset               = 1'b1;
      repeat (10) @(posedge fe_clk);
      #1 reset = 1'b0;

      // every width in both sampling modes, ends on width 4 trace clock
      foreach (widths[w]) begin
         for (int c = 0; c < 2; c++) begin
            trace_width     = widths[w];
            trace_clock_sel = c[0];
            send_random(24);
         end
      end

      // lock, then lose it by resync and by width change
      send_sync_bytes(16);
      wait_lock();
      resync = 1'b1;
      send_sync_bytes(1);
      resync = 1'b0;
      wait_lock();
      trace_width = WIDTH_2;
      send_sync_bytes(4);
      trace_width = WIDTH_4;
      send_sync_bytes(2);
      wait_lock();

      // rule 0 on the newest byte, rule 1 on its low nibble
      pat_byte            = 8'($urandom);
      patterns[0]         = {pat_byte, 56'd0};
      masks[0]            = {8'hff, 56'd0};
      patterns[1]         = {8'($urandom), 56'd0};
      masks[1]            = {8'h0f, 56'd0};
      pattern_enable      = 8'b0000_0011;
      pattern_trig_enable = 8'b0000_0001;
      capturing           = 1'b1;
      wait_counts(8'd20);

      // armed ext edges, then unarmed ones
      arm              = 1'b1;
      soft_trig_enable = 1'b1;
      pulse_ext(4);
      arm = 1'b0;
      pulse_ext(4);

      // fifo words in both sampling modes
      for (int c = 1; c >= 0; c--) begin
         trace_clock_sel = c[0];
         repeat (40) begin
            next_cycle();
            trace_data   = 8'($urandom);
            fifo_wr_req  = 1'($urandom);
            fifo_command = fe_cmd_e'(2'($urandom % 3));
            fifo_time    = 16'($urandom);
         end
      end
      next_cycle();
      fifo_wr_req     = 1'b0;
      trace_clock_sel = 1'b1;

      // raw capture, sync frames first
      pattern_enable      = '0;
      pattern_trig_enable = '0;
      capturing           = 1'b0;
      send_sync_bytes(16);
      wait_lock();
      send_sync_bytes(8);
      capture_raw = 1'b1;
      capturing   = 1'b1;
      sync_only   = 1'b1;
      send_sync_bytes(40);
      sync_only = 1'b0;
      wait_raw_event();
      capture_raw = 1'b0;
      capturing   = 1'b0;
      send_random(4);

      $display("errors: %0d assertion, %0d timeout", assert_errors, timeout_errors);
      if (assert_errors == 0 && timeout_errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;  // free running, even duty

endmodule

`default_nettype wire

/* rtl/fe_capture_trace.sv */
`default_nettype none

module fe_capture_trace #(
   parameter int MATCH_RULES = 8
) (
   input  wire logic                                              fe_clk,
   input  wire logic                                              reset,
   // trace port
   input  wire logic [7:0]                                        trace_data,
   input  wire logic                                              trace_clock_sel,
   input  wire trace_pkg::trace_width_e                           trace_width,
   input  wire logic                                              resync,
   // capture control
   input  wire logic                                              capture_raw,
   input  wire logic                                              record_syncs,
   input  wire logic                                              capturing,
   // match rules and trigger
   input  wire logic [MATCH_RULES-1:0][trace_pkg::BUFFER_BITS-1:0] patterns,
   input  wire logic [MATCH_RULES-1:0][trace_pkg::BUFFER_BITS-1:0] masks,
   input  wire logic [MATCH_RULES-1:0]                            pattern_enable,
   input  wire logic [MATCH_RULES-1:0]                            pattern_trig_enable,
   input  wire logic                                              soft_trig_enable,
   input  wire logic                                              arm,
   input  wire logic                                              no_arm,
   input  wire logic                                              ext_trig,
   // fifo request side
   input  wire logic                                              fifo_wr_req,
   input  wire trace_pkg::fe_cmd_e                                fifo_command,
   input  wire logic [trace_pkg::FULL_TIME_BITS-1:0]              fifo_time,
   output logic                                                   trace_event,
   output trace_pkg::fe_cmd_e                                     data_cmd,
   output logic                                                   sync_locked,
   output logic      [trace_pkg::BUFFER_BITS-1:0]                 rev_buffer,
   output logic      [MATCH_RULES-1:0][trace_pkg::COUNT_BITS-1:0] trace_counts,
   output logic      [trace_pkg::BUFFER_BITS-1:0]                 matched_data,
   output logic      [trace_pkg::FIFO_WORD_BITS-1:0]              fifo_data,
   output logic                                                   fifo_wr,
   output logic                                                   trigger_match
);
   import trace_pkg::*;

   logic                   capturing_r;
   logic                   capture_raw_r;
   logic                   byte_valid;
   logic                   recording;
   logic [MATCH_RULES-1:0] match_bits;
   logic [MATCH_RULES-1:0] match_rule;

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         capturing_r   <= 1'b0;
         capture_raw_r <= 1'b0;
      end else begin
         capturing_r   <= capturing;
         capture_raw_r <= capture_raw;
      end
   end

   // raw mode streams filtered bytes, else pattern hits
   assign trace_event = capture_raw_r ? (recording && byte_valid) : (|match_bits);
   assign data_cmd    = capture_raw_r ? CMD_STAT : CMD_DATA;

   //////////////////////////////////////////////////
   // front end blocks
   //////////////////////////////////////////////////
   trace_shifter u_shifter (
      .fe_clk, .reset, .trace_data, .trace_clock_sel, .trace_width, .rev_buffer
   );

   trace_sync u_sync (
      .fe_clk, .reset, .rev_buffer, .trace_width, .trace_clock_sel, .resync,
      .sync_locked, .byte_valid
   );

   sync_filter u_filter (
      .fe_clk, .reset, .rev_buffer, .byte_valid, .capturing_r, .record_syncs, .recording
   );

   pattern_matcher #(.MATCH_RULES(MATCH_RULES)) u_matcher (
      .fe_clk, .reset, .rev_buffer, .byte_valid, .capturing_r, .patterns, .masks,
      .pattern_enable, .pattern_trig_enable, .soft_trig_enable, .arm, .no_arm,
      .ext_trig, .match_bits, .match_rule, .matched_data, .trigger_match
   );

   match_counters #(.MATCH_RULES(MATCH_RULES)) u_counters (
      .fe_clk, .reset, .match_bits, .trace_counts
   );

   fifo_writer #(.MATCH_RULES(MATCH_RULES)) u_fifo_writer (
      .fe_clk, .reset, .fifo_wr_req, .fifo_command, .fifo_time, .match_rule,
      .rev_buffer, .trace_clock_sel, .fifo_data, .fifo_wr
   );

endmodule

`default_nettype wire

/* rtl/fifo_writer.sv */
`default_nettype none

module fifo_writer #(
   parameter int MATCH_RULES = 8
) (
   input  wire logic                                fe_clk,
   input  wire logic                                reset,
   input  wire logic                                fifo_wr_req,
   input  wire trace_pkg::fe_cmd_e                  fifo_command,
   input  wire logic [trace_pkg::FULL_TIME_BITS-1:0] fifo_time,
   input  wire logic [MATCH_RULES-1:0]              match_rule,
   input  wire logic [trace_pkg::BUFFER_BITS-1:0]   rev_buffer,
   input  wire logic                                trace_clock_sel,
   output logic      [trace_pkg::FIFO_WORD_BITS-1:0] fifo_data,
   output logic                                     fifo_wr
);
   import trace_pkg::*;

   // status byte position, assumes 4-bit port
   localparam int STAT_TOP_TRACE  = 31;
   localparam int STAT_TOP_TARGET = 43;

   logic [DATA_BITS-1:0] stat_byte;

   assign stat_byte = trace_clock_sel ? rev_buffer[STAT_TOP_TRACE -: DATA_BITS] :
                                        rev_buffer[STAT_TOP_TARGET -: DATA_BITS];

   always_ff @(posedge fe_clk) begin
      if (reset)
         fifo_wr <= 1'b0;
      else
         fifo_wr <= fifo_wr_req;  // no back-pressure
   end

   //////////////////////////////////////////////////
   // word formatting per command
   //////////////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (fifo_wr_req) begin
         fifo_data[0 +: CMD_BITS] <= fifo_command;
         case (fifo_command)
            CMD_DATA: begin
               fifo_data[TIME_START +: SHORT_TIME_BITS] <= fifo_time[SHORT_TIME_BITS-1:0];
               fifo_data[DATA_START +: DATA_BITS] <= DATA_BITS'(match_rule);  // fit to 8
            end
            CMD_STAT: begin
               fifo_data[TIME_START +: SHORT_TIME_BITS] <= fifo_time[SHORT_TIME_BITS-1:0];
               fifo_data[DATA_START +: DATA_BITS] <= stat_byte;
            end
            CMD_TIME: fifo_data[TIME_START +: FULL_TIME_BITS] <= fifo_time;  // whole 16 bits
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* matcher/match_counters.sv */
`default_nettype none

module match_counters #(
   parameter int MATCH_RULES = 8
) (
   input  wire logic                                            fe_clk,
   input  wire logic                                            reset,
   input  wire logic [MATCH_RULES-1:0]                          match_bits,
   output logic      [MATCH_RULES-1:0][trace_pkg::COUNT_BITS-1:0] trace_counts
);
   import trace_pkg::*;

   // one counter per rule, wraps
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         trace_counts <= '0;
      end else begin
         for (int i = 0; i < MATCH_RULES; i++) begin
            if (match_bits[i])
               trace_counts[i] <= trace_counts[i] + COUNT_BITS'(1);
         end
      end
   end

endmodule

`default_nettype wire

/* matcher/pattern_matcher.sv */
`default_nettype none

module pattern_matcher #(
   parameter int MATCH_RULES = 8
) (
   input  wire logic                                              fe_clk,
   input  wire logic                                              reset,
   input  wire logic [trace_pkg::BUFFER_BITS-1:0]                 rev_buffer,
   input  wire logic                                              byte_valid,
   input  wire logic                                              capturing_r,
   input  wire logic [MATCH_RULES-1:0][trace_pkg::BUFFER_BITS-1:0] patterns,
   input  wire logic [MATCH_RULES-1:0][trace_pkg::BUFFER_BITS-1:0] masks,
   input  wire logic [MATCH_RULES-1:0]                            pattern_enable,
   input  wire logic [MATCH_RULES-1:0]                            pattern_trig_enable,
   input  wire logic                                              soft_trig_enable,
   input  wire logic                                              arm,
   input  wire logic                                              no_arm,
   input  wire logic                                              ext_trig,
   output logic      [MATCH_RULES-1:0]                            match_bits,
   output logic      [MATCH_RULES-1:0]                            match_rule,
   output logic      [trace_pkg::BUFFER_BITS-1:0]                 matched_data,
   output logic                                                   trigger_match
);
   import trace_pkg::*;

   logic any_match;
   logic trig_hit;    // some trigger-enabled rule hit now
   logic trig_hit_r;
   logic ext_trig_r;  // for rising edge

   //////////////////////////////////////////////////
   // masked compare per rule
   //////////////////////////////////////////////////
   for (genvar i = 0; i < MATCH_RULES; i++) begin : g_rule
      logic [BUFFER_BITS-1:0] diff;
      assign diff = (rev_buffer ^ patterns[i]) & masks[i];
      // trig enable lets a rule fire before capture starts
      assign match_bits[i] = (diff == '0) && pattern_enable[i] && byte_valid &&
                             (capturing_r || pattern_trig_enable[i]);
   end

   assign any_match = |match_bits;
   assign trig_hit  = |(match_bits & pattern_trig_enable);

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         trig_hit_r   <= 1'b0;
         ext_trig_r   <= 1'b0;
         match_rule   <= '0;
         matched_data <= '0;
      end else begin
         trig_hit_r <= trig_hit;
         ext_trig_r <= ext_trig;
         if (any_match) begin
            match_rule   <= match_bits;  // goes out with the next data word
            matched_data <= rev_buffer;
         end
      end
   end

   // ext edge or a fresh pattern hit, only while armed
   assign trigger_match = (arm || no_arm) &&
                          ((ext_trig && !ext_trig_r && soft_trig_enable) ||
                           (trig_hit && !trig_hit_r));

endmodule

`default_nettype wire

/* rtl/sync_filter.sv */
`default_nettype none

module sync_filter (
   input  wire logic                             fe_clk,
   input  wire logic                             reset,
   input  wire logic [trace_pkg::BUFFER_BITS-1:0] rev_buffer,
   input  wire logic                             byte_valid,
   input  wire logic                             capturing_r,
   input  wire logic                             record_syncs,  // keep sync frames too
   output logic                                  recording
);
   import trace_pkg::*;

   logic all_sync;  // buffer is nothing but sync frames
   logic stop_sync; // frame-aligned stop word

   always_comb begin
      all_sync = 1'b0;
      for (int i = 0; i < SYNC_ALL_COUNT; i++) begin
         all_sync |= (rev_buffer == SYNC_ALL_WORDS[i]);
      end
   end

   always_comb begin
      stop_sync = 1'b0;
      for (int i = 0; i < SYNC_STOP_COUNT; i++) begin
         stop_sync |= (rev_buffer == SYNC_STOP_WORDS[i]);
      end
   end

   //////////////////////////////////////////////////
   // start on real data, stop on a full sync buffer
   //////////////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         recording <= 1'b0;
      end else if (!capturing_r) begin
         recording <= 1'b0;
      end else if (byte_valid) begin
         if (stop_sync)
            recording <= 1'b0;
         else if (!all_sync || record_syncs)
            recording <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* rtl/trace_sync.sv */
`default_nettype none

module trace_sync (
   input  wire logic                             fe_clk,
   input  wire logic                             reset,
   input  wire logic [trace_pkg::BUFFER_BITS-1:0] rev_buffer,
   input  wire trace_pkg::trace_width_e          trace_width,
   input  wire logic                             trace_clock_sel,
   input  wire logic                             resync,       // fe_clk pulse
   output logic                                  sync_locked,
   output logic                                  byte_valid    // buffer is byte aligned
);
   import trace_pkg::*;

   trace_width_e width_r;    // last width, for change detect
   logic [2:0]   align_cnt;  // wraps, that is expected
   logic         head_ok;
   logic         tail_ok;

   // catches half and full sync frames
   assign head_ok = rev_buffer[BUFFER_BITS-1 -: $bits(SYNC_HEAD)] == SYNC_HEAD;
   assign tail_ok = rev_buffer[$bits(SYNC_TAIL)-1:0] == SYNC_TAIL;

   //////////////////////////////////////////////////
   // lock and alignment
   //////////////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         sync_locked <= 1'b0;
         align_cnt   <= '0;
         width_r     <= WIDTH_1;
      end else begin
         width_r <= trace_width;
         if (resync || (trace_width != width_r)) begin  // relock after width change
            sync_locked <= 1'b0;
            align_cnt   <= '0;
         end else if (!sync_locked && head_ok && tail_ok) begin
            sync_locked <= 1'b1;
            align_cnt   <= 3'd1;
         end else if (sync_locked) begin
            align_cnt <= align_cnt + 3'd1;
         end
      end
   end

   // trace clock: every 4/2/1 cycles for width 1/2/4
   // target clock halves the bits per cycle, so 8/4/2
   always_comb begin
      byte_valid = 1'b0;
      if (sync_locked) begin
         case (trace_width)
            WIDTH_1: byte_valid = trace_clock_sel ? (align_cnt[1:0] == 2'd0) :
                                                    (align_cnt == 3'd0);
            WIDTH_2: byte_valid = trace_clock_sel ? !align_cnt[0] :
                                                    (align_cnt[1:0] == 2'd0);
            WIDTH_4: byte_valid = trace_clock_sel ? 1'b1 : !align_cnt[0];
            default: byte_valid = 1'b0;  // unsupported width
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/trace_shifter.sv */
`default_nettype none

module trace_shifter (
   input  wire logic                             fe_clk,
   input  wire logic                             reset,
   input  wire logic [7:0]                       trace_data,
   input  wire logic                             trace_clock_sel,  // 1: both nibble phases
   input  wire trace_pkg::trace_width_e          trace_width,
   output logic      [trace_pkg::BUFFER_BITS-1:0] rev_buffer
);
   import trace_pkg::*;

   logic [BUFFER_BITS-1:0] buffer;    // newest bits at the bottom
   logic [7:0]             lane_rev;  // lane 0 lands in bit 7

   assign lane_rev = {<<{trace_data}};

   //////////////////////////////////////////////////
   // shift in active lanes, lane 0 first
   //////////////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         buffer <= '0;
      end else begin
         case (trace_width)
            WIDTH_4: buffer <= trace_clock_sel ?
                                  {buffer[BUFFER_BITS-9:0], lane_rev} :
                                  {buffer[BUFFER_BITS-5:0], lane_rev[7:4]};
            WIDTH_2: buffer <= trace_clock_sel ?
                                  {buffer[BUFFER_BITS-5:0], lane_rev[7:6], lane_rev[3:2]} :
                                  {buffer[BUFFER_BITS-3:0], lane_rev[7:6]};
            // width 1, unsupported codes fall here too
            default: buffer <= trace_clock_sel ?
                                  {buffer[BUFFER_BITS-3:0], lane_rev[7], lane_rev[3]} :
                                  {buffer[BUFFER_BITS-2:0], lane_rev[7]};
         endcase
      end
   end

   // newest sample ends up at the top
   assign rev_buffer = {<<{buffer}};

endmodule

`default_nettype wire

/* common/trace_pkg.sv */
`default_nettype none

package trace_pkg;

   //////////////////////////////////////////////////
   // buffer and fifo word layout
   //////////////////////////////////////////////////
   localparam int BUFFER_BITS     = 64;  // trace history, sync tables depend on it
   localparam int COUNT_BITS      = 8;   // per-rule hit counter
   localparam int FIFO_WORD_BITS  = 18;
   localparam int CMD_BITS        = 2;   // command field sits at bit 0
   localparam int TIME_START      = 2;
   localparam int SHORT_TIME_BITS = 8;
   localparam int FULL_TIME_BITS  = 16;  // time command fills bits 17:2
   localparam int DATA_START      = 10;
   localparam int DATA_BITS       = 8;

   // fifo command field
   typedef enum logic [CMD_BITS-1:0] {
      CMD_DATA = 2'd0,
      CMD_TIME = 2'd1,
      CMD_STAT = 2'd2
   } fe_cmd_e;

   // trace port width, other codes never give a valid byte
   typedef enum logic [2:0] {
      WIDTH_1 = 3'd1,
      WIDTH_2 = 3'd2,
      WIDTH_4 = 3'd4
   } trace_width_e;

   //////////////////////////////////////////////////
   // sync frame words, as seen in the reversed buffer
   //////////////////////////////////////////////////
   localparam int SYNC_ALL_COUNT  = 17;
   localparam int SYNC_STOP_COUNT = 2;

   // mixes of short and full sync frames, not exhaustive
   localparam logic [BUFFER_BITS-1:0] SYNC_ALL_WORDS [SYNC_ALL_COUNT] = '{
      64'h7fff7fff7fff7fff, 64'hff7fff7fff7fff7f, 64'h7fffffff7fffffff,
      64'hff7fffffff7fffff, 64'hffff7fffffff7fff, 64'hffffff7fffffff7f,
      64'h7fff7fff7fffffff, 64'hff7fff7fff7fffff, 64'hffff7fff7fff7fff,
      64'hffffff7fff7fff7f, 64'h7fffffff7fff7fff, 64'hff7fffffff7fff7f,
      64'hffff7fffffff7fff, 64'hffffff7fffffff7f, 64'h7fff7fffffff7fff,
      64'hff7fff7fffffff7f, 64'hffff7fff7fffffff
   };

   // stop only on frame-aligned words so the last byte is not cut
   localparam logic [BUFFER_BITS-1:0] SYNC_STOP_WORDS [SYNC_STOP_COUNT] = '{
      64'hff7fff7fff7fff7f, 64'hff7fffffff7fffff
   };

   localparam logic [15:0] SYNC_HEAD = 16'h7fff;  // top of reversed buffer
   localparam logic [7:0]  SYNC_TAIL = 8'hff;     // bottom of reversed buffer

endpackage

`default_nettype wire
